// File: compress.f
hw/compress_pkg.sv
hw/cmp_stream_if.sv
hw/poly_mem.sv
hw/compress_ctrl.sv
hw/compress_unit.sv
hw/compress_packer.sv
hw/compress_top.sv
testbench/compress_tb.sv

// File: Bender.yml
package:
  name: compress

sources:
  - files:
      - hw/compress_pkg.sv
      - hw/cmp_stream_if.sv
      - hw/poly_mem.sv
      - hw/compress_ctrl.sv
      - hw/compress_unit.sv
      - hw/compress_packer.sv
      - hw/compress_top.sv
  - target: test
    files:
      - testbench/compress_tb.sv

// File: testbench/compress_testdata.txt
# run d src fill value dst words : src, value and dst in hex, fill is lcg or const
# bnd coeff d field : zap d src dst cycles from start to zeroize
run 1 000 lcg 000 00001000 32
run 4 100 lcg 000 00002000 128
run 5 200 lcg 000 00003000 160
run 10 300 lcg 000 00004000 320
run 11 0c0 lcg 000 0000a000 352
run 4 080 const 9a5 00005000 128
zap 10 180 00006000 150
run 10 2c0 lcg 000 00007000 320
bnd 0 11 0
bnd 832 11 512
bnd 1664 11 1024
bnd 1665 11 1024
bnd 2496 11 1536
bnd 3328 11 2047
bnd 0 1 0
bnd 832 1 0
bnd 1664 1 1
bnd 1665 1 1
bnd 2496 1 1
bnd 3328 1 0

// File: testbench/compress_tb.sv
// Testbench for the ML-KEM compression subsystem
// Replays run, boundary and zeroize records from the test data file, models a
// Wishbone slave with random ack delays and checks every written word and address

module compress_tb;
    import compress_pkg::*;

    localparam int NUM_POLY  = 4;
    localparam int MEM_DEPTH = 1024;
    localparam int RUN_WORDS = NUM_POLY * MLKEM_N / COEFFS_PER_WORD;
    localparam int BND_SRC   = 'h000;
    localparam int BND_DST   = 'h8000;
    localparam int REC_RUN   = 0;
    localparam int REC_BND   = 1;
    localparam int REC_ZAP   = 2;

    // One line of the data file, fields unused by a kind stay zero
    typedef struct packed {
        int kind;
        int d;
        int src;
        int dst;
        int fill_const;
        int value;
        int words;
        int coeff;
        int field;
        int cycles;
    } test_rec_t;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic start;
    cmp_mode_e mode;
    logic [CMP_MEM_ADDR_WIDTH-1:0] src_base_addr;
    logic [WB_DATA_WIDTH-1:0] dst_base_addr;
    logic load_en;
    logic [CMP_MEM_ADDR_WIDTH-1:0] load_addr;
    logic [COEFFS_PER_WORD*COEFF_WIDTH-1:0] load_data;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [WB_DATA_WIDTH-1:0] wb_adr;
    logic [WB_DATA_WIDTH-1:0] wb_dat;
    logic [3:0] wb_sel;
    logic wb_ack;
    logic done;

    test_rec_t recs[$];
    int ref_coef [RUN_WORDS*COEFFS_PER_WORD];
    logic [WB_DATA_WIDTH-1:0] exp_words[$];
    logic [WB_DATA_WIDTH-1:0] bus_words[$];
    logic [WB_DATA_WIDTH-1:0] bus_addrs[$];
    int unsigned lcg_state = 69458;
    int cycle_count = 0;
    int cycle_limit = 0;
    int hold_cycles = 0;
    int ack_wait = 0;
    bit bus_busy = 1'b0;

    compress_top #(
        .NUM_POLY  (NUM_POLY),
        .MEM_DEPTH (MEM_DEPTH)
    ) uut (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .start         (start),
        .mode          (mode),
        .src_base_addr (src_base_addr),
        .dst_base_addr (dst_base_addr),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat        (wb_dat),
        .wb_sel        (wb_sel),
        .wb_ack        (wb_ack),
        .done          (done)
    );

    always #2 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // round(x * 2^d / q) mod 2^d, with rounding half up written as (2n + q) / 2q
    function automatic int compressed(int x, int d);
        int n;
        n = x << d;
        return ((2 * n + MLKEM_Q) / (2 * MLKEM_Q)) % (1 << d);
    endfunction

    function automatic cmp_mode_e mode_of(int d);
        case (d)
            4:       return CMP_D4;
            5:       return CMP_D5;
            10:      return CMP_D10;
            11:      return CMP_D11;
            default: return CMP_D1;
        endcase
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_word(input logic [WB_DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [WB_DATA_WIDTH-1:0] got, exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %0h, expected %0h", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // Parse the whole data file up front so the cycle budget is known before reset
    task automatic read_records();
        int fd;
        int code;
        int need;
        int f1, f2, f3, f4, f5;
        logic [8*16-1:0] kind;
        logic [8*16-1:0] fill;
        logic [8*128-1:0] line;
        test_rec_t r;
        fd = $fopen("testbench/compress_testdata.txt", "r");
        if (fd == 0) begin
            $display("The test data file could not be opened");
            stop_run();
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            r = '0;
            code = 0;
            need = 0;
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "run") begin
                need = 6;
                code = $fscanf(fd, "%d %h %s %h %h %d", f1, f2, fill, f3, f4, f5);
                r.kind = REC_RUN;
                r.d = f1;
                r.src = f2;
                r.fill_const = (fill == "const");
                r.value = f3;
                r.dst = f4;
                r.words = f5;
            end else if (kind == "bnd") begin
                need = 3;
                code = $fscanf(fd, "%d %d %d", f1, f2, f3);
                r.kind = REC_BND;
                r.coeff = f1;
                r.d = f2;
                r.field = f3;
                r.src = BND_SRC;
                r.dst = BND_DST;
                r.fill_const = 1;
                r.words = NUM_POLY * 8 * f2;
            end else if (kind == "zap") begin
                need = 4;
                code = $fscanf(fd, "%d %h %h %d", f1, f2, f3, f4);
                r.kind = REC_ZAP;
                r.d = f1;
                r.src = f2;
                r.dst = f3;
                r.cycles = f4;
            end else begin
                $display("The test data file holds a record of unknown kind");
                stop_run();
            end
            if (code != need && need != 0) begin
                $display("The test data file holds a malformed record");
                stop_run();
            end
            if (need != 0) begin
                recs.push_back(r);
            end
        end
        $fclose(fd);
    endtask

    // Fill the run's source words, optionally forcing coefficient 0 of word 0
    task automatic load_poly(input int src, input int fill_const, input int value, input int first);
        logic [COEFFS_PER_WORD*COEFF_WIDTH-1:0] word;
        int c;
        for (int w = 0; w < RUN_WORDS; w++) begin
            for (int i = 0; i < COEFFS_PER_WORD; i++) begin
                c = fill_const ? value : int'(lcg_next() % MLKEM_Q);
                if (w == 0 && i == 0 && first >= 0) begin
                    c = first;
                end
                ref_coef[w*COEFFS_PER_WORD+i] = c;
                word[i*COEFF_WIDTH +: COEFF_WIDTH] = c[COEFF_WIDTH-1:0];
            end
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = CMP_MEM_ADDR_WIDTH'(src + w);
            load_data = word;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    // Pack d bits per coefficient LSB first, coefficient order as in memory
    task automatic build_expected(input int d);
        logic [WB_DATA_WIDTH-1:0] acc;
        int nbits;
        int v;
        exp_words.delete();
        acc = '0;
        nbits = 0;
        foreach (ref_coef[k]) begin
            v = compressed(ref_coef[k], d);
            for (int b = 0; b < d; b++) begin
                acc[nbits] = v[b];
                nbits++;
                if (nbits == WB_DATA_WIDTH) begin
                    exp_words.push_back(acc);
                    nbits = 0;
                end
            end
        end
    endtask

    task automatic start_run(input int d, input int src, input int dst);
        @(negedge clk);
        mode          = mode_of(d);
        src_base_addr = CMP_MEM_ADDR_WIDTH'(src);
        dst_base_addr = WB_DATA_WIDTH'(dst);
        bus_words.delete();
        bus_addrs.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (done !== 1'b0) begin
            report_mismatch("done did not fall in the cycle after start");
        end
    endtask

    task automatic run_and_check(input test_rec_t r, input int first);
        load_poly(r.src, r.fill_const, r.value, first);
        build_expected(r.d);
        start_run(r.d, r.src, r.dst);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        check_count(bus_words.size(), NUM_POLY * 8 * r.d, "words written");
        if (r.kind == REC_RUN) begin
            check_count(r.words, NUM_POLY * 8 * r.d, "word count from the data file");
        end
        foreach (bus_words[i]) begin
            check_addr(bus_addrs[i], WB_DATA_WIDTH'(r.dst + i), $sformatf("address %0d", i));
            check_word(bus_words[i], exp_words[i], $sformatf("word %0d", i));
        end
    endtask

    // Zeroize lands while words are still going out, then the bus must stay quiet
    task automatic zeroize_mid_run(input test_rec_t r);
        load_poly(r.src, 0, 0, -1);
        start_run(r.d, r.src, r.dst);
        repeat (r.cycles) @(negedge clk);
        if (done !== 1'b0 || bus_words.size() == 0) begin
            $display("The zeroize record did not fall inside an active run");
            stop_run();
        end
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        repeat (16) begin
            if (wb_cyc !== 1'b0) begin
                report_mismatch("wb_cyc is high after zeroize");
            end
            if (done !== 1'b1) begin
                report_mismatch("done is low after zeroize");
            end
            @(negedge clk);
        end
    endtask

    // Wishbone slave, acks after 0 to 3 wait cycles and keeps what it receives
    always @(negedge clk) begin
        if (uut.stream_if.hold === 1'b1) begin
            hold_cycles++;
        end
        if (wb_ack || wb_cyc !== 1'b1) begin
            wb_ack = 1'b0;
            bus_busy = 1'b0;
        end else begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                ack_wait = int'(lcg_next() % 4);
            end
            if (ack_wait == 0) begin
                if (wb_stb !== 1'b1 || wb_we !== 1'b1 || wb_sel !== 4'hf) begin
                    report_mismatch("stb, we or sel wrong during a write cycle");
                end
                bus_words.push_back(wb_dat);
                bus_addrs.push_back(wb_adr);
                wb_ack = 1'b1;
                bus_busy = 1'b0;
            end else begin
                ack_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        start = 1'b0;
        mode = CMP_D1;
        src_base_addr = '0;
        dst_base_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        wb_ack = 1'b0;
        read_records();
        foreach (recs[i]) begin
            cycle_limit += (recs[i].kind == REC_ZAP) ? recs[i].cycles : 8 * recs[i].words;
        end
        cycle_limit += 200;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        foreach (recs[i]) begin
            case (recs[i].kind)
                REC_RUN: run_and_check(recs[i], -1);
                REC_BND: begin
                    run_and_check(recs[i], recs[i].coeff);
                    check_word(bus_words[0] & WB_DATA_WIDTH'((1 << recs[i].d) - 1),
                               WB_DATA_WIDTH'(recs[i].field),
                               $sformatf("field of %0d at d=%0d", recs[i].coeff, recs[i].d));
                end
                default: zeroize_mid_run(recs[i]);
            endcase
        end
        if (hold_cycles == 0) begin
            $display("The packer never raised hold, so back-pressure was not exercised");
            stop_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: hw/compress_top.sv
// ML-KEM compression subsystem
// Reads NUM_POLY polynomials from the polynomial memory, compresses each coefficient
// to d bits and writes the packed words out through a Wishbone classic master

module compress_top #(
    parameter int NUM_POLY  = 4,
    parameter int MEM_DEPTH = 1024
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    start,
    input  compress_pkg::cmp_mode_e mode,
    input  logic [compress_pkg::CMP_MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic [compress_pkg::WB_DATA_WIDTH-1:0]      dst_base_addr,
    input  logic                    load_en,
    input  logic [compress_pkg::CMP_MEM_ADDR_WIDTH-1:0] load_addr,
    input  logic [compress_pkg::COEFFS_PER_WORD*compress_pkg::COEFF_WIDTH-1:0] load_data,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [compress_pkg::WB_DATA_WIDTH-1:0]      wb_adr,
    output logic [compress_pkg::WB_DATA_WIDTH-1:0]      wb_dat,
    output logic [3:0]              wb_sel,
    input  logic                    wb_ack,
    output logic                    done
);
    import compress_pkg::*;

    mem_if_t mem_rd_req;
    logic [COEFFS_PER_WORD*COEFF_WIDTH-1:0] rd_data;
    logic mem_rd_data_valid;
    logic rd_done;

    cmp_stream_if stream_if ();

    compress_ctrl #(
        .NUM_POLY (NUM_POLY)
    ) u_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .cmp_enable        (start),
        .src_base_addr     (src_base_addr),
        .mem_rd_req        (mem_rd_req),
        .mem_rd_data_valid (mem_rd_data_valid),
        .stream            (stream_if.ctrl),
        .rd_done           (rd_done)
    );

    poly_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem (
        .clk        (clk),
        .mem_rd_req (mem_rd_req),
        .rd_data    (rd_data),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    // The final-word flag rides beside the memory data into the compressor
    compress_unit u_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .mode          (mode),
        .rd_data       (rd_data),
        .rd_data_valid (mem_rd_data_valid),
        .rd_last       (stream_if.rd_last),
        .stream        (stream_if.producer)
    );

    compress_packer u_packer (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .mode          (mode),
        .stream        (stream_if.consumer),
        .rd_done       (rd_done),
        .dst_base_addr (dst_base_addr),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat        (wb_dat),
        .wb_sel        (wb_sel),
        .wb_ack        (wb_ack),
        .done          (done)
    );

endmodule

// File: hw/compress_packer.sv
// Compressed bit packer and Wishbone classic write master
// Buffers compressed groups, packs 4*d bits per group LSB first into 32-bit words
// and writes them to consecutive addresses from the destination base

module compress_packer (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  compress_pkg::cmp_mode_e mode,
    cmp_stream_if.consumer          stream,
    input  logic                    rd_done,
    input  logic [compress_pkg::WB_DATA_WIDTH-1:0] dst_base_addr,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [compress_pkg::WB_DATA_WIDTH-1:0] wb_adr,
    output logic [compress_pkg::WB_DATA_WIDTH-1:0] wb_dat,
    output logic [3:0]              wb_sel,
    input  logic                    wb_ack,
    output logic                    done
);
    import compress_pkg::*;

    localparam int BUF_DEPTH = 4;
    localparam int GRP_W     = COEFFS_PER_WORD * CMP_MAX_D;
    // Up to 31 leftover bits plus one 44-bit group
    localparam int ACC_W     = 76;

    logic [COEFFS_PER_WORD-1:0][CMP_MAX_D-1:0] buf_coeffs [BUF_DEPTH];
    logic       buf_last [BUF_DEPTH];
    logic [1:0] wr_ptr, rd_ptr;
    logic [2:0] count;

    logic [ACC_W-1:0] acc;
    logic [6:0]       acc_cnt;
    logic [6:0]       grp_cnt;
    logic [GRP_W-1:0] grp_bits;
    logic [3:0]       d;
    logic             flush_q;
    logic             push, pop, wr_start;

    assign d       = cmp_d_bits(mode);
    assign grp_cnt = 7'(d) << 2;

    // Two groups can still arrive after hold rises, so hold at half full
    assign stream.hold = (count >= 3'd2);

    // Fields of the oldest group laid side by side, coefficient 0 lowest
    always_comb begin
        grp_bits = '0;
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            grp_bits = grp_bits | (GRP_W'(buf_coeffs[rd_ptr][i]) << (i * d));
        end
    end

    // A full word, or any rest after the final group, goes out when the bus is free
    assign wr_start = ~wb_cyc & ((acc_cnt >= 7'd32) | (flush_q & (acc_cnt != 7'd0)));
    assign push     = stream.valid;
    assign pop      = (count != 3'd0) & ~wr_start & (acc_cnt < 7'd32);

    always_ff @(posedge clk) begin
        if (push) begin
            buf_coeffs[wr_ptr] <= stream.coeffs;
            buf_last[wr_ptr]   <= stream.last;
        end
        if (wr_start) begin
            wb_dat <= acc[WB_DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            acc     <= '0;
            acc_cnt <= '0;
            flush_q <= 1'b0;
            wb_cyc  <= 1'b0;
            wb_adr  <= '0;
        end else if (zeroize) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            acc     <= '0;
            acc_cnt <= '0;
            flush_q <= 1'b0;
            wb_cyc  <= 1'b0;
            wb_adr  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + 3'(push) - 3'(pop);

            // Shift out the word being written, else append the next group
            if (wr_start) begin
                acc     <= acc >> WB_DATA_WIDTH;
                acc_cnt <= (acc_cnt >= 7'd32) ? acc_cnt - 7'd32 : 7'd0;
            end else if (pop) begin
                acc     <= acc | (ACC_W'(grp_bits) << acc_cnt);
                acc_cnt <= acc_cnt + grp_cnt;
            end

            if (pop & buf_last[rd_ptr]) begin
                flush_q <= 1'b1;
            end else if (acc_cnt == 7'd0) begin
                flush_q <= 1'b0;
            end

            // Classic cycle stays up with stable address and data until ack
            if (wr_start) begin
                wb_cyc <= 1'b1;
            end else if (wb_cyc & wb_ack) begin
                wb_cyc <= 1'b0;
            end

            if (wb_cyc & wb_ack) begin
                wb_adr <= wb_adr + 1'b1;
            end else if (done) begin
                wb_adr <= dst_base_addr;
            end
        end
    end

    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc;
    assign wb_sel = 4'hf;

    // Nothing left in the reader, the stream, the buffer, the bit store or on the bus
    assign done = rd_done & ~stream.valid & (count == 3'd0) & (acc_cnt == 7'd0) & ~wb_cyc;

endmodule

// File: hw/compress_unit.sv
// Coefficient compressor
// One pipeline stage computing round(x * 2^d / q) mod 2^d for four coefficients,
// with the division done by a fixed reciprocal and a single correction step

module compress_unit (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  compress_pkg::cmp_mode_e mode,
    input  logic [compress_pkg::COEFFS_PER_WORD*compress_pkg::COEFF_WIDTH-1:0] rd_data,
    input  logic                    rd_data_valid,
    input  logic                    rd_last,
    cmp_stream_if.producer          stream
);
    import compress_pkg::*;

    // Largest numerator is 3328 * 2^11 + 1664, which fits 23 bits
    localparam int NUM_W       = COEFF_WIDTH + CMP_MAX_D;
    localparam int RECIP_SHIFT = 24;
    localparam int RECIP       = (1 << RECIP_SHIFT) / MLKEM_Q;
    localparam int PROD_W      = NUM_W + 13;

    logic [3:0] d;
    logic [COEFF_WIDTH-1:0] mask;
    logic [COEFFS_PER_WORD-1:0][CMP_MAX_D-1:0] comp;

    assign d    = cmp_d_bits(mode);
    assign mask = (COEFF_WIDTH'(1) << d) - 1'b1;

    // Reciprocal estimate is at most one below the true quotient
    always_comb begin
        logic [NUM_W-1:0]       num;
        logic [PROD_W-1:0]      prod;
        logic [COEFF_WIDTH-1:0] quo;
        logic [NUM_W-1:0]       rem;
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            num  = (NUM_W'(rd_data[i*COEFF_WIDTH +: COEFF_WIDTH]) << d) + NUM_W'(MLKEM_Q / 2);
            prod = PROD_W'(num) * PROD_W'(RECIP);
            quo  = prod[RECIP_SHIFT +: COEFF_WIDTH];
            rem  = num - NUM_W'(quo * MLKEM_Q);
            if (rem >= NUM_W'(MLKEM_Q)) begin
                quo = quo + 1'b1;
            end
            comp[i] = CMP_MAX_D'(quo & mask);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
        end else if (zeroize) begin
            stream.valid <= 1'b0;
            stream.last  <= 1'b0;
        end else begin
            stream.valid <= rd_data_valid;
            stream.last  <= rd_data_valid & rd_last;
        end
    end

    always_ff @(posedge clk) begin
        stream.coeffs <= comp;
    end

endmodule

// File: hw/compress_ctrl.sv
// Compression read controller
// Walks NUM_POLY polynomials of the source memory one word per cycle,
// repeats the current address while the packer holds, and marks the final word

module compress_ctrl #(
    parameter int NUM_POLY = 4
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize,
    input  logic                  cmp_enable,
    input  logic [compress_pkg::CMP_MEM_ADDR_WIDTH-1:0] src_base_addr,
    output compress_pkg::mem_if_t mem_rd_req,
    output logic                  mem_rd_data_valid,
    cmp_stream_if.ctrl            stream,
    output logic                  rd_done
);
    import compress_pkg::*;

    // Memory words in one run, each polynomial spans 64 words
    localparam int RUN_WORDS = NUM_POLY * (MLKEM_N / COEFFS_PER_WORD);

    logic [CMP_MEM_ADDR_WIDTH-1:0] rd_addr;
    logic [CMP_MEM_ADDR_WIDTH-1:0] last_addr;
    logic last_addr_rd;
    logic rd_accept;

    cmp_read_state_e state_ps, state_ns;

    logic arc_idle_to_mem;
    logic arc_mem_to_idle;

    // A read counts only when the packer is not holding
    always_comb begin
        last_addr       = src_base_addr + CMP_MEM_ADDR_WIDTH'(RUN_WORDS - 1);
        last_addr_rd    = (rd_addr == last_addr);
        rd_accept       = (state_ps == CMP_RD_MEM) & ~stream.hold;
        arc_idle_to_mem = (state_ps == CMP_RD_IDLE) & cmp_enable;
        arc_mem_to_idle = rd_accept & last_addr_rd;
    end

    always_comb begin
        case (state_ps)
            CMP_RD_IDLE: state_ns = arc_idle_to_mem ? CMP_RD_MEM : CMP_RD_IDLE;
            CMP_RD_MEM:  state_ns = arc_mem_to_idle ? CMP_RD_IDLE : CMP_RD_MEM;
            default:     state_ns = CMP_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_ps <= CMP_RD_IDLE;
        end else if (zeroize) begin
            state_ps <= CMP_RD_IDLE;
        end else begin
            state_ps <= state_ns;
        end
    end

    // Address counter loads the base on start and stands still under hold
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
        end else if (zeroize) begin
            rd_addr <= '0;
        end else if (arc_idle_to_mem) begin
            rd_addr <= src_base_addr;
        end else if (rd_accept) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // Valid and last follow the read by one cycle, in step with the memory data
    // A repeated read under hold returns data that nobody consumes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_rd_data_valid <= 1'b0;
            stream.rd_last    <= 1'b0;
        end else if (zeroize) begin
            mem_rd_data_valid <= 1'b0;
            stream.rd_last    <= 1'b0;
        end else begin
            mem_rd_data_valid <= rd_accept;
            stream.rd_last    <= arc_mem_to_idle;
        end
    end

    always_comb begin
        mem_rd_req.rd_wr_en = (state_ps == CMP_RD_MEM) ? RW_READ : RW_IDLE;
        mem_rd_req.addr     = rd_addr;
    end

    // Idle and no word still on its way out of the memory
    assign rd_done = (state_ps == CMP_RD_IDLE) & ~mem_rd_data_valid;

endmodule

// File: hw/poly_mem.sv
// Polynomial memory
// Four 12-bit coefficients per word, one registered read port and a load port
// through which the memory is filled

module poly_mem #(
    parameter int MEM_DEPTH = 1024
) (
    input  logic                    clk,
    input  compress_pkg::mem_if_t   mem_rd_req,
    output logic [compress_pkg::COEFFS_PER_WORD*compress_pkg::COEFF_WIDTH-1:0] rd_data,
    input  logic                    load_en,
    input  logic [compress_pkg::CMP_MEM_ADDR_WIDTH-1:0] load_addr,
    input  logic [compress_pkg::COEFFS_PER_WORD*compress_pkg::COEFF_WIDTH-1:0] load_data
);
    import compress_pkg::*;

    localparam int WORD_W = COEFFS_PER_WORD * COEFF_WIDTH;

    logic [WORD_W-1:0] mem [MEM_DEPTH];

    // Loads and reads share one clock, a read returns the word one cycle later
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (mem_rd_req.rd_wr_en == RW_READ) begin
            rd_data <= mem[mem_rd_req.addr];
        end
    end

endmodule

// File: hw/cmp_stream_if.sv
// Compressed coefficient stream
// Carries one group of four compressed fields from the compressor to the packer,
// the hold back-pressure to the read controller and the controller's last flag

interface cmp_stream_if;
    import compress_pkg::*;

    // Group of four fields, each zero-extended to the widest d
    logic [COEFFS_PER_WORD-1:0][CMP_MAX_D-1:0] coeffs;
    logic valid;
    logic last;

    // Packer buffer is close to full, reads must repeat
    logic hold;

    // Final address of the run was read, aligned with the memory data
    logic rd_last;

    modport producer (output valid, coeffs, last);
    modport consumer (input valid, coeffs, last, output hold);
    modport ctrl     (input hold, output rd_last);

endinterface

// File: hw/compress_pkg.sv
// Compression package for the ML-KEM compress subsystem
// Holds widths, ML-KEM constants, state and mode enums and the memory request type

package compress_pkg;

    // Polynomial memory geometry
    localparam int CMP_MEM_ADDR_WIDTH = 10;
    localparam int COEFF_WIDTH        = 12;
    localparam int COEFFS_PER_WORD    = 4;

    // ML-KEM ring parameters
    localparam int MLKEM_N = 256;
    localparam int MLKEM_Q = 3329;

    // Widest compressed field, used for d = 11
    localparam int CMP_MAX_D = 11;

    // Width of one word on the output bus
    localparam int WB_DATA_WIDTH = 32;

    typedef enum logic {
        RW_IDLE = 1'b0,
        RW_READ = 1'b1
    } rw_e;

    // Request into the polynomial memory, kind plus word address
    typedef struct packed {
        rw_e                           rd_wr_en;
        logic [CMP_MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

    typedef enum logic {
        CMP_RD_IDLE = 1'b0,
        CMP_RD_MEM  = 1'b1
    } cmp_read_state_e;

    // Compression modes, one per legal d of ML-KEM
    typedef enum logic [2:0] {
        CMP_D1  = 3'd0,
        CMP_D4  = 3'd1,
        CMP_D5  = 3'd2,
        CMP_D10 = 3'd3,
        CMP_D11 = 3'd4
    } cmp_mode_e;

    // Number of compressed bits per coefficient for a mode
    function automatic logic [3:0] cmp_d_bits(cmp_mode_e mode);
        case (mode)
            CMP_D4:  return 4'd4;
            CMP_D5:  return 4'd5;
            CMP_D10: return 4'd10;
            CMP_D11: return 4'd11;
            default: return 4'd1;
        endcase
    endfunction

endpackage
